// ==== design/dcache_defines.svh ====
// ====================
// Cache geometry macros
// ====================

`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Base geometry
`define DC_ADDR_WIDTH   32
`define DC_DATA_WIDTH   32
`define DC_LINE_SIZE    16
`define DC_CACHE_SIZE   256

// Derived from the geometry above
`define DC_LINE_COUNT   (`DC_CACHE_SIZE / `DC_LINE_SIZE)
`define DC_LINE_WIDTH   (`DC_LINE_SIZE * 8)

// Address field widths
`define DC_OFFSET_WIDTH $clog2(`DC_LINE_SIZE)
`define DC_INDEX_WIDTH  $clog2(`DC_LINE_COUNT)
`define DC_TAG_WIDTH    (`DC_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_OFFSET_WIDTH)

`endif

// ==== design/dcache_dt.sv ====
// ====================
// Request stage
// ====================

`timescale 1ns/10ps

module dcache_dt
    import dcache_types_pkg::*, dcache_op_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_stall,
    input  logic      i_valid,
    input  dc_req_t   i_req,
    output dc_stage_t o_stage
);

    localparam dc_byte_sel_t SEL_BYTE = dc_byte_sel_t'(1);
    localparam dc_byte_sel_t SEL_HALF = dc_byte_sel_t'(3);
    localparam dc_byte_sel_t SEL_WORD = '1;

    dc_stage_t    stage_d;
    dc_byte_sel_t byte_sel;

    // Byte lanes touched by the access, before alignment
    always_comb begin
        case (i_req.op)
            LB, LBU, SB: byte_sel = SEL_BYTE;
            LH, LHU, SH: byte_sel = SEL_HALF;
            default:     byte_sel = SEL_WORD; // Words and fills
        endcase
    end

    always_comb begin
        stage_d.valid     = i_valid;
        stage_d.op        = i_req.op;
        {stage_d.tag, stage_d.index, stage_d.offset} = i_req.addr;
        stage_d.wdata     = i_req.wdata;
        stage_d.fill_line = i_req.fill_line;
        stage_d.byte_sel  = byte_sel;
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_stage <= stage_d;
        end
        if (i_rst) begin
            o_stage.valid <= 1'b0;
        end
    end

endmodule

// ==== design/dcache_op_pkg.sv ====
// ====================
// Operation enum and request, stage and response structs
// ====================

package dcache_op_pkg;

    import dcache_types_pkg::*;

    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        FILL
    } dc_op_t;

    typedef struct packed {
        dc_op_t   op;
        dc_addr_t addr;
        dc_word_t wdata;     // Store data
        dc_line_t fill_line; // Fill data
    } dc_req_t;

    typedef struct packed {
        logic         valid;
        dc_op_t       op;
        dc_tag_t      tag;
        dc_index_t    index;
        dc_offset_t   offset;
        dc_word_t     wdata;
        dc_line_t     fill_line;
        dc_byte_sel_t byte_sel;
    } dc_stage_t;

    typedef struct packed {
        dc_op_t   op;
        dc_addr_t addr;
        logic     hit;
        logic     dirty;     // Victim line dirty
        dc_word_t data;
    } dc_rsp_t;

    function automatic logic dc_is_load(dc_op_t op);
        return (op == LB) || (op == LH) || (op == LW) || (op == LBU) || (op == LHU);
    endfunction

    function automatic logic dc_is_store(dc_op_t op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

// ==== design/dcache_ram.sv ====
// ====================
// Tag, valid, dirty and data arrays
// ====================

`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_ram
    import dcache_types_pkg::*, dcache_op_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_stall,
    input  dc_stage_t i_stage,

    input  logic      i_wr_en,
    input  dc_index_t i_wr_index,
    input  dc_tag_t   i_wr_tag,
    input  logic      i_wr_dirty,
    input  dc_line_t  i_wr_line,

    output dc_stage_t o_stage,
    output dc_tag_t   o_tag,
    output logic      o_line_valid,
    output logic      o_dirty,
    output dc_line_t  o_line
);

    localparam int LINES = `DC_LINE_COUNT;

    dc_tag_t          tag_mem  [LINES];
    dc_line_t         line_mem [LINES];
    logic [LINES-1:0] valid_q;
    logic [LINES-1:0] dirty_q;

    logic bypass;

    // Write lands on the same edge the read samples
    assign bypass = i_wr_en && (i_wr_index == i_stage.index);

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (i_wr_en) begin
            valid_q[i_wr_index] <= 1'b1;
            dirty_q[i_wr_index] <= i_wr_dirty;
        end
    end

    // Registered read, held under stall
    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_stage <= i_stage;
            if (bypass) begin
                o_tag        <= i_wr_tag;
                o_line_valid <= 1'b1;
                o_dirty      <= i_wr_dirty;
                o_line       <= i_wr_line;
            end else begin
                o_tag        <= tag_mem[i_stage.index];
                o_line_valid <= valid_q[i_stage.index];
                o_dirty      <= dirty_q[i_stage.index];
                o_line       <= line_mem[i_stage.index];
            end
        end
        if (i_rst) begin
            o_stage.valid <= 1'b0;
        end
    end

endmodule

// ==== design/dcache_rsp.sv ====
// ====================
// Response stage with hit check, load align and store merge
// ====================

`timescale 1ns/10ps

`include "dcache_defines.svh"

module dcache_rsp
    import dcache_types_pkg::*, dcache_op_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_stall,
    input  dc_stage_t i_stage,
    input  dc_tag_t   i_tag,
    input  logic      i_line_valid,
    input  logic      i_dirty,
    input  dc_line_t  i_line,

    output logic      o_wr_en,
    output dc_index_t o_wr_index,
    output dc_tag_t   o_wr_tag,
    output logic      o_wr_dirty,
    output dc_line_t  o_wr_line,

    output logic      o_rsp_valid,
    output dc_rsp_t   o_rsp
);

    localparam int DW     = `DC_DATA_WIDTH;
    localparam int BYTES  = DW / 8;
    localparam int BOFF_W = $clog2(BYTES);

    logic tag_match;
    logic hit;
    logic is_fill;
    logic is_load;
    logic is_store;

    logic [`DC_OFFSET_WIDTH-BOFF_W-1:0] word_sel;
    logic [BOFF_W-1:0]                  byte_off;

    dc_word_t     cur_word;
    dc_word_t     ld_shift;
    dc_word_t     ld_mask;
    dc_word_t     ld_masked;
    dc_word_t     ld_data;
    dc_word_t     st_data;
    dc_byte_sel_t st_sel;
    dc_word_t     merged_word;
    dc_line_t     merged_line;
    dc_rsp_t      rsp_next;

    assign is_fill   = (i_stage.op == FILL);
    assign is_load   = dc_is_load(i_stage.op);
    assign is_store  = dc_is_store(i_stage.op);
    assign tag_match = (i_tag == i_stage.tag);
    assign hit       = (i_line_valid && tag_match) || is_fill;

    assign word_sel = i_stage.offset[`DC_OFFSET_WIDTH-1:BOFF_W];
    assign byte_off = i_stage.offset[BOFF_W-1:0];
    assign cur_word = i_line[word_sel*DW +: DW];

    // Load path
    always_comb begin
        ld_shift = cur_word >> (byte_off * 8);
        for (int i = 0; i < BYTES; i++) begin
            ld_mask[i*8 +: 8] = {8{i_stage.byte_sel[i]}};
        end
        ld_masked = ld_shift & ld_mask;
        case (i_stage.op)
            LB:      ld_data = {{(DW-8){ld_masked[7]}}, ld_masked[7:0]};
            LH:      ld_data = {{(DW-16){ld_masked[15]}}, ld_masked[15:0]};
            default: ld_data = ld_masked; // LW, LBU, LHU
        endcase
    end

    // Store path
    always_comb begin
        st_data = i_stage.wdata << (byte_off * 8);
        st_sel  = i_stage.byte_sel << byte_off;
        for (int i = 0; i < BYTES; i++) begin
            merged_word[i*8 +: 8] = st_sel[i] ? st_data[i*8 +: 8] : cur_word[i*8 +: 8];
        end
        merged_line = i_line;
        merged_line[word_sel*DW +: DW] = merged_word;
    end

    // Array write port
    assign o_wr_en    = i_stage.valid && !i_stall && (is_fill || (is_store && hit));
    assign o_wr_index = i_stage.index;
    assign o_wr_tag   = i_stage.tag;
    assign o_wr_dirty = is_store;
    assign o_wr_line  = is_fill ? i_stage.fill_line : merged_line;

    always_comb begin
        rsp_next.op    = i_stage.op;
        rsp_next.addr  = {i_stage.tag, i_stage.index, i_stage.offset};
        rsp_next.hit   = hit;
        rsp_next.dirty = i_line_valid && !tag_match && i_dirty; // Line it would evict
        rsp_next.data  = (is_load && hit) ? ld_data : '0;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rsp_valid <= 1'b0;
        end else if (!i_stall) begin
            o_rsp_valid <= i_stage.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall && i_stage.valid) begin
            o_rsp <= rsp_next;
        end
    end

endmodule

// ==== design/dcache_top.sv ====
// ====================
// Data cache top level
// ====================

`timescale 1ns/10ps

module dcache_top
    import dcache_types_pkg::*, dcache_op_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,

    input  logic    i_req_valid,
    input  dc_req_t i_req,
    output logic    o_req_ready,

    output logic    o_rsp_valid,
    output dc_rsp_t o_rsp,
    input  logic    i_rsp_ready
);

    logic      stall;
    dc_stage_t dt_stage;
    dc_stage_t ram_stage;

    logic      wr_en;
    dc_index_t wr_index;
    dc_tag_t   wr_tag;
    logic      wr_dirty;
    dc_line_t  wr_line;

    dc_tag_t   rd_tag;
    logic      rd_line_valid;
    logic      rd_dirty;
    dc_line_t  rd_line;

    // Response held by the consumer freezes every stage
    assign stall       = o_rsp_valid && !i_rsp_ready;
    assign o_req_ready = !stall;

    dcache_dt u_dt (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (stall),
        .i_valid (i_req_valid && o_req_ready),
        .i_req   (i_req),
        .o_stage (dt_stage)
    );

    dcache_ram u_ram (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (stall),
        .i_stage      (dt_stage),
        .i_wr_en      (wr_en),
        .i_wr_index   (wr_index),
        .i_wr_tag     (wr_tag),
        .i_wr_dirty   (wr_dirty),
        .i_wr_line    (wr_line),
        .o_stage      (ram_stage),
        .o_tag        (rd_tag),
        .o_line_valid (rd_line_valid),
        .o_dirty      (rd_dirty),
        .o_line       (rd_line)
    );

    dcache_rsp u_rsp (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_stall      (stall),
        .i_stage      (ram_stage),
        .i_tag        (rd_tag),
        .i_line_valid (rd_line_valid),
        .i_dirty      (rd_dirty),
        .i_line       (rd_line),
        .o_wr_en      (wr_en),
        .o_wr_index   (wr_index),
        .o_wr_tag     (wr_tag),
        .o_wr_dirty   (wr_dirty),
        .o_wr_line    (wr_line),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp)
    );

endmodule

// ==== design/dcache_types_pkg.sv ====
// ====================
// Storage and address vector types
// ====================

`include "dcache_defines.svh"

package dcache_types_pkg;

    // Full address and its fields
    typedef logic [`DC_ADDR_WIDTH-1:0]   dc_addr_t;
    typedef logic [`DC_TAG_WIDTH-1:0]    dc_tag_t;
    typedef logic [`DC_INDEX_WIDTH-1:0]  dc_index_t;
    typedef logic [`DC_OFFSET_WIDTH-1:0] dc_offset_t;

    // Payload widths
    typedef logic [`DC_DATA_WIDTH-1:0]   dc_word_t;
    typedef logic [`DC_LINE_WIDTH-1:0]   dc_line_t;

    // One bit per byte of a word
    typedef logic [`DC_DATA_WIDTH/8-1:0] dc_byte_sel_t;

endpackage

// ==== files.f ====
+incdir+design
+incdir+verification
design/dcache_types_pkg.sv
design/dcache_op_pkg.sv
design/dcache_dt.sv
design/dcache_ram.sv
design/dcache_rsp.sv
design/dcache_top.sv
verification/tb_dcache.sv

// ==== verification/dcache_cases.txt ====
# op addr wdata fill_line hit dirty data, all hex except the hit and dirty bits
# lines starting with # are skipped
# cold miss, then fill line 1 and read it back
LW   00001010 00000000 00000000000000000000000000000000 0 0 00000000
FILL 00001010 00000000 CAFE123400FF807F7A5B8C9D81F27F80 1 0 00000000
LW   00001010 00000000 00000000000000000000000000000000 1 0 81F27F80
LW   00001014 00000000 00000000000000000000000000000000 1 0 7A5B8C9D
LW   00001018 00000000 00000000000000000000000000000000 1 0 00FF807F
LW   0000101C 00000000 00000000000000000000000000000000 1 0 CAFE1234
LB   00001010 00000000 00000000000000000000000000000000 1 0 FFFFFF80
LB   00001011 00000000 00000000000000000000000000000000 1 0 0000007F
LB   00001012 00000000 00000000000000000000000000000000 1 0 FFFFFFF2
LB   00001013 00000000 00000000000000000000000000000000 1 0 FFFFFF81
LBU  00001010 00000000 00000000000000000000000000000000 1 0 00000080
LBU  00001013 00000000 00000000000000000000000000000000 1 0 00000081
LH   00001010 00000000 00000000000000000000000000000000 1 0 00007F80
LH   00001012 00000000 00000000000000000000000000000000 1 0 FFFF81F2
LHU  00001010 00000000 00000000000000000000000000000000 1 0 00007F80
LHU  00001012 00000000 00000000000000000000000000000000 1 0 000081F2
LH   00001016 00000000 00000000000000000000000000000000 1 0 00007A5B
LH   00001014 00000000 00000000000000000000000000000000 1 0 FFFF8C9D
LBU  00001015 00000000 00000000000000000000000000000000 1 0 0000008C
# stores merge only their selected bytes
SB   0000101A 123456AB 00000000000000000000000000000000 1 0 00000000
LW   00001018 00000000 00000000000000000000000000000000 1 0 00AB807F
SH   0000101C DEAD5566 00000000000000000000000000000000 1 0 00000000
SW   00001014 11223344 00000000000000000000000000000000 1 0 00000000
LW   0000101C 00000000 00000000000000000000000000000000 1 0 CAFE5566
LW   00001014 00000000 00000000000000000000000000000000 1 0 11223344
# dirty victim at index 1
LW   00002010 00000000 00000000000000000000000000000000 0 1 00000000
FILL 00002010 00000000 0123456789ABCDEF0011223344556677 1 1 00000000
LW   00002010 00000000 00000000000000000000000000000000 1 0 44556677
LW   00001010 00000000 00000000000000000000000000000000 0 0 00000000
# store miss writes nothing
SB   00003022 000000EE 00000000000000000000000000000000 0 0 00000000
LW   00003020 00000000 00000000000000000000000000000000 0 0 00000000

// ==== verification/tb_dcache_checks.svh ====
// ====================
// Response compare tasks
// ====================

`ifndef TB_DCACHE_CHECKS_SVH
`define TB_DCACHE_CHECKS_SVH

task automatic check_word(input int case_no, input string what,
                          input dc_word_t want, input dc_word_t got);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("ERR %0t case %0d: %s expected %08h, got %08h",
                 $time, case_no, what, want, got);
    end
endtask

task automatic check_addr(input int case_no, input dc_addr_t want, input dc_addr_t got);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("ERR %0t case %0d: addr expected %08h, got %08h",
                 $time, case_no, want, got);
    end
endtask

task automatic check_flag(input int case_no, input string what,
                          input logic want, input logic got);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("ERR %0t case %0d: %s expected %b, got %b",
                 $time, case_no, what, want, got);
    end
endtask

task automatic check_op(input int case_no, input dc_op_t want, input dc_op_t got);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("ERR %0t case %0d: op expected %s, got %s",
                 $time, case_no, want.name(), got.name());
    end
endtask

`endif

// ==== verification/tb_dcache.sv ====
// ====================
// Data cache testbench with case reader, driver, checker and back-pressure
// ====================

`timescale 1ns/10ps

module tb_dcache
    import dcache_types_pkg::*, dcache_op_pkg::*;
();

    localparam int    TIMEOUT_CYCLES = 200;
    localparam string CASE_FILE      = "verification/dcache_cases.txt";

    logic    clk;
    logic    rst;
    logic    req_valid;
    dc_req_t req;
    logic    req_ready;
    logic    rsp_valid;
    dc_rsp_t rsp;
    logic    rsp_ready;

    dc_rsp_t     exp_q[$];
    int          case_q[$];
    int          case_count;
    int          done_count;
    int          check_count;
    int          error_count;
    logic [31:0] lcg_state;

    `include "tb_dcache_checks.svh"

    dcache_top DUT (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_req_ready (req_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp       (rsp),
        .i_rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic parse_op(input string name, output dc_op_t op);
        dc_op_t cand;
        cand = cand.first();
        op   = LB;
        for (int i = 0; i < cand.num(); i++) begin
            if (cand.name() == name) begin
                op = cand;
                return 1'b1;
            end
            cand = cand.next();
        end
        return 1'b0;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic send_request(input dc_req_t r, input dc_rsp_t want, input int cno);
        int waited;
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(want);
        case_q.push_back(cno);
        waited = 0;
        @(posedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("Timed out waiting for the cache to accept a request");
            end
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // Response ready low one cycle in three
    initial begin
        lcg_state = 32'd68;
        rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
            rsp_ready = (lcg_state[31:16] % 3) != 0;
        end
    end

    initial begin : response_checker
        dc_rsp_t want;
        int      cno;
        int      errs_before;
        int      idle;
        idle = 0;
        forever begin
            @(posedge clk);
            if (!rst && rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("A response arrived with no request outstanding");
                end else begin
                    want        = exp_q.pop_front();
                    cno         = case_q.pop_front();
                    errs_before = error_count;
                    check_op(cno, want.op, rsp.op);
                    check_addr(cno, want.addr, rsp.addr);
                    check_flag(cno, "hit", want.hit, rsp.hit);
                    check_flag(cno, "dirty", want.dirty, rsp.dirty);
                    check_word(cno, "data", want.data, rsp.data);
                    $display("case %0d %s %08h: %s", cno, want.op.name(), want.addr,
                             (error_count == errs_before) ? "ok" : "mismatch");
                    done_count++;
                    idle = 0;
                end
            end else if (exp_q.size() != 0) begin
                idle++;
                if (idle > TIMEOUT_CYCLES) begin
                    abort_run("Timed out waiting for a response from the cache");
                end
            end
        end
    end

    initial begin : main_sequence
        int          fd;
        int          n;
        int          waited;
        logic        known;
        string       tok;
        string       skip;
        dc_op_t      op;
        dc_addr_t    addr;
        dc_word_t    wdata;
        dc_line_t    fill;
        logic        hit;
        logic        dirty;
        dc_word_t    data;
        dc_req_t     r;
        dc_rsp_t     want;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        case_count  = 0;
        done_count  = 0;
        check_count = 0;
        error_count = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(0, "rsp_valid after reset", 1'b0, rsp_valid);
        check_flag(0, "req_ready after reset", 1'b1, req_ready);
        $display("reset state: %s", (error_count == 0) ? "ok" : "mismatch");
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run("Could not open the case file");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                n = $fgets(skip, fd); // Rest of a comment line
            end else begin
                n     = $fscanf(fd, "%h %h %h %b %b %h", addr, wdata, fill, hit, dirty, data);
                known = parse_op(tok, op);
                if (n != 6 || !known) begin
                    abort_run("Found a malformed line in the case file");
                end
                r          = '0;
                r.op       = op;
                r.addr     = addr;
                r.wdata    = wdata;
                r.fill_line = fill;
                want       = '0;
                want.op    = op;
                want.addr  = addr;
                want.hit   = hit;
                want.dirty = dirty;
                want.data  = data;
                case_count++;
                send_request(r, want, case_count);
            end
        end
        $fclose(fd);
        req_valid = 1'b0;
        waited    = 0;
        while (done_count < case_count) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("Timed out waiting for the last responses");
            end
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // Catch any duplicate response
        $display("%0d cases, %0d checks, %0d errors", case_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
